/* logic/srcPkg.sv */
//==========================================================================
// Shared definitions for the single-bus datapath
// Word and memory sizes, ALU opcodes and the instruction word layout
//==========================================================================

package srcPkg;

    // Data word and register file
    localparam int dataWidth = 32;
    localparam int regCount = 16;
    localparam int regIdxWidth = 4;

    // Main memory
    localparam int memDepth = 512;
    localparam int memAddrWidth = 9;

    // ALU control
    localparam int opWidth = 5;

    localparam logic [opWidth-1:0] opNop = 5'd0;
    localparam logic [opWidth-1:0] opAdd = 5'd1;
    localparam logic [opWidth-1:0] opSub = 5'd2;
    localparam logic [opWidth-1:0] opShr = 5'd5;
    localparam logic [opWidth-1:0] opShl = 5'd6;
    localparam logic [opWidth-1:0] opShra = 5'd7;
    localparam logic [opWidth-1:0] opRor = 5'd8;
    localparam logic [opWidth-1:0] opRol = 5'd9;
    localparam logic [opWidth-1:0] opAnd = 5'd10;
    localparam logic [opWidth-1:0] opOr = 5'd11;
    localparam logic [opWidth-1:0] opNeg = 5'd12;
    localparam logic [opWidth-1:0] opNot = 5'd15;

    // Instruction word, read as register format or as immediate format
    typedef union packed {
        struct packed {
            logic [opWidth-1:0] op;
            logic [regIdxWidth-1:0] ra;
            logic [regIdxWidth-1:0] rb;
            logic [regIdxWidth-1:0] rc;
            logic [14:0] unused;
        } regForm;
        struct packed {
            logic [opWidth-1:0] op;
            logic [regIdxWidth-1:0] ra;
            logic [regIdxWidth-1:0] rb;
            // Two's complement constant, widened by the select block
            logic [18:0] constant;
        } immForm;
    } instrWord;

endpackage

/* logic/busIf.sv */
//==========================================================================
// Datapath bus bundle
// Every bus source value plus the resolved bus word
//==========================================================================
`timescale 1ns/10ps

interface busIf;
    import srcPkg::*;

    // Source values, one per driving block
    logic [dataWidth-1:0] regData;
    logic [dataWidth-1:0] zData;
    logic [dataWidth-1:0] mdrData;
    logic [dataWidth-1:0] pcData;
    logic [dataWidth-1:0] inPortData;
    logic [dataWidth-1:0] constData;

    // Word currently on the bus
    logic [dataWidth-1:0] busData;

    // Bus multiplexer side, which also owns PC and the input port
    modport busPort (
        input regData, zData, mdrData, constData,
        output pcData, inPortData, busData
    );

    modport regPort (output regData, input busData);
    modport aluPort (output zData, input busData);
    modport memPort (output mdrData, input busData);
    modport constPort (output constData);

endinterface

/* logic/alu.sv */
//==========================================================================
// ALU with Y input and Z result registers
// Z takes f(Y, bus) for the opcode, or bus + 1 for PC increment
//==========================================================================
`timescale 1ns/10ps

module alu (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      yIn,
    input  logic                      zIn,
    input  logic                      incPc,
    input  logic [srcPkg::opWidth-1:0] opcode,
    busIf.aluPort                     bus
);
    import srcPkg::*;

    logic [dataWidth-1:0] yReg;
    logic [dataWidth-1:0] zReg;
    logic [dataWidth-1:0] result;
    logic [4:0] shiftAmt;
    logic [2*dataWidth-1:0] yPair;
    logic [2*dataWidth-1:0] rorWide;
    logic [2*dataWidth-1:0] rolWide;

    assign shiftAmt = bus.busData[4:0];

    // Rotates as shifts of Y placed next to itself
    assign yPair = {yReg, yReg};
    assign rorWide = yPair >> shiftAmt;
    assign rolWide = yPair << shiftAmt;

    always_comb begin
        case (opcode)
            opNop:   result = '0;
            opAdd:   result = yReg + bus.busData;
            opSub:   result = yReg - bus.busData;
            opShr:   result = yReg >> shiftAmt;
            opShl:   result = yReg << shiftAmt;
            opShra:  result = $signed(yReg) >>> shiftAmt;
            opRor:   result = rorWide[dataWidth-1:0];
            opRol:   result = rolWide[2*dataWidth-1:dataWidth];
            opAnd:   result = yReg & bus.busData;
            opOr:    result = yReg | bus.busData;
            // Unary ops work on the bus alone
            opNeg:   result = -bus.busData;
            opNot:   result = ~bus.busData;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (yIn) begin
                yReg <= bus.busData;
            end
            if (zIn) begin
                // PC increment bypasses Y and the opcode
                zReg <= incPc ? bus.busData + dataWidth'(1) : result;
            end
        end
    end

    assign bus.zData = zReg;

endmodule

/* logic/memUnit.sv */
//==========================================================================
// Memory unit
// MAR, MDR and a 512-word synchronous RAM
//==========================================================================
`timescale 1ns/10ps

module memUnit (
    input  logic  clk,
    input  logic  arstN,
    input  logic  marIn,
    input  logic  mdrIn,
    input  logic  read,
    input  logic  write,
    busIf.memPort bus
);
    import srcPkg::*;

    logic [memAddrWidth-1:0] mar;
    logic [dataWidth-1:0] mdr;
    logic [dataWidth-1:0] mem [memDepth];

    // Address and data registers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (marIn) begin
                mar <= bus.busData[memAddrWidth-1:0];
            end
            if (mdrIn) begin
                // read picks memory, otherwise MDR loads from the bus
                mdr <= read ? mem[mar] : bus.busData;
            end
        end
    end

    // Write port, MDR into the word at MAR
    always_ff @(posedge clk) begin
        if (write) begin
            mem[mar] <= mdr;
        end
    end

    assign bus.mdrData = mdr;

endmodule

/* logic/regFile.sv */
//==========================================================================
// General register file
// Sixteen 32-bit registers, R0 reads as zero for base addressing
//==========================================================================
`timescale 1ns/10ps

module regFile (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       baOut,
    input  logic [srcPkg::regCount-1:0] writeSel,
    input  logic [srcPkg::regCount-1:0] readSel,
    busIf.regPort                      bus
);
    import srcPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    // Selected registers take the bus word
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < regCount; i++) begin
                if (writeSel[i]) begin
                    regs[i] <= bus.busData;
                end
            end
        end
    end

    // One-hot read, merged by OR
    always_comb begin
        bus.regData = '0;
        for (int i = 0; i < regCount; i++) begin
            // R0 under baOut stands for a zero base
            if (readSel[i] && !(i == 0 && baOut)) begin
                bus.regData = bus.regData | regs[i];
            end
        end
    end

endmodule

/* logic/selectEncode.sv */
//==========================================================================
// Register select and constant encode
// Turns IR register fields into one-hot selects, widens the immediate
//==========================================================================
`timescale 1ns/10ps

module selectEncode (
    input  srcPkg::instrWord            ir,
    input  logic                        gra,
    input  logic                        grb,
    input  logic                        grc,
    input  logic                        rin,
    input  logic                        rout,
    output logic [srcPkg::regCount-1:0] writeSel,
    output logic [srcPkg::regCount-1:0] readSel,
    busIf.constPort                     bus
);
    import srcPkg::*;

    logic [regIdxWidth-1:0] regIdx;
    logic [regCount-1:0] decoded;

    // Field chosen by the active group strobe
    assign regIdx = ({regIdxWidth{gra}} & ir.regForm.ra)
                  | ({regIdxWidth{grb}} & ir.regForm.rb)
                  | ({regIdxWidth{grc}} & ir.regForm.rc);

    always_comb begin
        decoded = '0;
        if (gra || grb || grc) begin
            decoded[regIdx] = 1'b1;
        end
    end

    assign writeSel = rin ? decoded : '0;
    assign readSel = rout ? decoded : '0;

    // Signed cast makes the size cast copy the sign bit upward
    assign bus.constData = dataWidth'(signed'(ir.immForm.constant));

endmodule

/* logic/systemBus.sv */
//==========================================================================
// Bus control
// PC, IR and input port registers, and the bus source multiplexer
//==========================================================================
`timescale 1ns/10ps

module systemBus (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        pcIn,
    input  logic                        irIn,
    input  logic                        inPortIn,
    input  logic                        zOut,
    input  logic                        mdrOut,
    input  logic                        pcOut,
    input  logic                        inPortOut,
    input  logic                        cOut,
    input  logic                        rout,
    input  logic [srcPkg::dataWidth-1:0] inPortData,
    busIf.busPort                       bus,
    output srcPkg::instrWord            ir
);
    import srcPkg::*;

    logic [dataWidth-1:0] pcReg;
    logic [dataWidth-1:0] inPortReg;
    logic [5:0] outSel;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcReg <= '0;
            ir <= '0;
            inPortReg <= '0;
        end else begin
            if (pcIn) begin
                pcReg <= bus.busData;
            end
            if (irIn) begin
                ir <= bus.busData;
            end
            // Input port samples the outside word, not the bus
            if (inPortIn) begin
                inPortReg <= inPortData;
            end
        end
    end

    assign bus.pcData = pcReg;
    assign bus.inPortData = inPortReg;

    // Out-strobes gathered into one selection word
    assign outSel = {rout, zOut, mdrOut, pcOut, inPortOut, cOut};

    // No source or a clash leaves the bus at zero
    always_comb begin
        case (outSel)
            6'b100000: bus.busData = bus.regData;
            6'b010000: bus.busData = bus.zData;
            6'b001000: bus.busData = bus.mdrData;
            6'b000100: bus.busData = bus.pcData;
            6'b000010: bus.busData = bus.inPortData;
            6'b000001: bus.busData = bus.constData;
            default:   bus.busData = '0;
        endcase
    end

endmodule

/* logic/datapathTop.sv */
//==========================================================================
// Single-bus 32-bit datapath
// Register file, ALU, memory and bus logic driven by external strobes
//==========================================================================
`timescale 1ns/10ps

module datapathTop (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        read,
    input  logic                        write,
    input  logic                        baOut,
    input  logic                        rin,
    input  logic                        rout,
    input  logic                        gra,
    input  logic                        grb,
    input  logic                        grc,
    input  logic                        marIn,
    input  logic                        mdrIn,
    input  logic                        yIn,
    input  logic                        zIn,
    input  logic                        pcIn,
    input  logic                        irIn,
    input  logic                        incPc,
    input  logic                        inPortIn,
    input  logic                        zOut,
    input  logic                        mdrOut,
    input  logic                        pcOut,
    input  logic                        inPortOut,
    input  logic                        cOut,
    input  logic [srcPkg::opWidth-1:0]   opcode,
    input  logic [srcPkg::dataWidth-1:0] inPortData,
    output logic [srcPkg::dataWidth-1:0] busData
);
    import srcPkg::*;

    busIf bus ();

    instrWord ir;
    logic [regCount-1:0] writeSel;
    logic [regCount-1:0] readSel;

    assign busData = bus.busData;

    systemBus systemBus_i (
        .clk(clk), .arstN(arstN),
        .pcIn(pcIn), .irIn(irIn), .inPortIn(inPortIn),
        .zOut(zOut), .mdrOut(mdrOut), .pcOut(pcOut),
        .inPortOut(inPortOut), .cOut(cOut), .rout(rout),
        .inPortData(inPortData),
        .bus(bus.busPort),
        .ir(ir)
    );

    selectEncode selectEncode_i (
        .ir(ir),
        .gra(gra), .grb(grb), .grc(grc),
        .rin(rin), .rout(rout),
        .writeSel(writeSel), .readSel(readSel),
        .bus(bus.constPort)
    );

    regFile regFile_i (
        .clk(clk), .arstN(arstN), .baOut(baOut),
        .writeSel(writeSel), .readSel(readSel),
        .bus(bus.regPort)
    );

    alu alu_i (
        .clk(clk), .arstN(arstN),
        .yIn(yIn), .zIn(zIn), .incPc(incPc), .opcode(opcode),
        .bus(bus.aluPort)
    );

    memUnit memUnit_i (
        .clk(clk), .arstN(arstN),
        .marIn(marIn), .mdrIn(mdrIn), .read(read), .write(write),
        .bus(bus.memPort)
    );

endmodule

/* verification/datapath_assert.sv */
//==========================================================================
// Bus checks for the datapath
// Single driver on the bus and an idle bus at zero
//==========================================================================
`timescale 1ns/10ps

module datapathAssert (
    input logic                         clk,
    input logic                         arstN,
    input logic                         rout,
    input logic                         zOut,
    input logic                         mdrOut,
    input logic                         pcOut,
    input logic                         inPortOut,
    input logic                         cOut,
    input logic [srcPkg::dataWidth-1:0] busData
);
    logic [5:0] outSel;

    assign outSel = {rout, zOut, mdrOut, pcOut, inPortOut, cOut};

    oneSource: assert property (@(posedge clk) disable iff (!arstN) $onehot0(outSel))
        else $error("more than one bus source enabled: %b", outSel);

    idleBusZero: assert property (@(posedge clk) (outSel == '0) |-> (busData == '0))
        else $error("bus not zero with no source enabled: %h", busData);
endmodule

bind datapathTop datapathAssert datapathAssert_i (
    .clk(clk), .arstN(arstN), .rout(rout), .zOut(zOut), .mdrOut(mdrOut),
    .pcOut(pcOut), .inPortOut(inPortOut), .cOut(cOut), .busData(busData)
);

/* verification/datapathTb.sv */
//==========================================================================
// Datapath testbench
// Acts as control sequencer and checks bus results against a model
//==========================================================================
`timescale 1ns/10ps

module datapathTb;
    import srcPkg::*;

    logic clk, arstN, read, write, baOut, rin, rout, gra, grb, grc, marIn, mdrIn;
    logic yIn, zIn, pcIn, irIn, incPc, inPortIn, zOut, mdrOut, pcOut, inPortOut, cOut;
    logic [opWidth-1:0] opcode;
    logic [dataWidth-1:0] inPortData, busData, expWord, rngState;
    logic doCheck;
    int errors, cycles;

    // One mask bit per strobe from read down to cOut
    localparam logic [20:0] mRead = 21'd1 << 20;
    localparam logic [20:0] mWrite = 21'd1 << 19;
    localparam logic [20:0] mBaOut = 21'd1 << 18;
    localparam logic [20:0] mRin = 21'd1 << 17;
    localparam logic [20:0] mRout = 21'd1 << 16;
    localparam logic [20:0] mGra = 21'd1 << 15;
    localparam logic [20:0] mGrb = 21'd1 << 14;
    localparam logic [20:0] mGrc = 21'd1 << 13;
    localparam logic [20:0] mMarIn = 21'd1 << 12;
    localparam logic [20:0] mMdrIn = 21'd1 << 11;
    localparam logic [20:0] mYIn = 21'd1 << 10;
    localparam logic [20:0] mZIn = 21'd1 << 9;
    localparam logic [20:0] mPcIn = 21'd1 << 8;
    localparam logic [20:0] mIrIn = 21'd1 << 7;
    localparam logic [20:0] mIncPc = 21'd1 << 6;
    localparam logic [20:0] mInPortIn = 21'd1 << 5;
    localparam logic [20:0] mZOut = 21'd1 << 4;
    localparam logic [20:0] mMdrOut = 21'd1 << 3;
    localparam logic [20:0] mPcOut = 21'd1 << 2;
    localparam logic [20:0] mInPortOut = 21'd1 << 1;
    localparam logic [20:0] mCOut = 21'd1;

    datapathTop datapathTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // Expected ALU result for Y as first operand and bus as second
    function automatic logic [31:0] refAlu(logic [4:0] op, logic [31:0] y, logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            opAdd:   return y + b;
            opSub:   return y - b;
            opShr:   return y >> sh;
            opShl:   return y << sh;
            opShra:  return $signed(y) >>> sh;
            opRor:   return (y >> sh) | (y << (6'd32 - sh));
            opRol:   return (y << sh) | (y >> (6'd32 - sh));
            opAnd:   return y & b;
            opOr:    return y | b;
            opNeg:   return -b;
            opNot:   return ~b;
            default: return '0;
        endcase
    endfunction

    task automatic checkWord(string name, logic [dataWidth-1:0] got, logic [dataWidth-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkInstr(string name, instrWord got, instrWord exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Bus is settled by the falling edge of a step
    always @(negedge clk) begin
        if (doCheck) begin
            checkWord("busData", busData, expWord);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("Timeout after %0d cycles with %0d errors", cycles, errors);
            $display("Test failures found");
            $finish;
        end
    end

    // One control step whose strobes the next call clears
    task automatic step(logic [20:0] s, logic [4:0] op, logic [31:0] port, logic chk,
                        logic [31:0] expV);
        @(posedge clk);
        {read, write, baOut, rin, rout, gra, grb, grc, marIn, mdrIn, yIn, zIn,
         pcIn, irIn, incPc, inPortIn, zOut, mdrOut, pcOut, inPortOut, cOut} <= s;
        opcode <= op;
        inPortData <= port;
        doCheck <= chk;
        expWord <= expV;
        @(negedge clk);
    endtask

    task automatic act(logic [20:0] s);
        step(s, opNop, '0, 1'b0, '0);
    endtask

    task automatic expectBus(logic [20:0] s, logic [31:0] v);
        step(s, opNop, '0, 1'b1, v);
    endtask

    task automatic busFromPort(logic [20:0] s, logic [31:0] v);
        step(mInPortIn, opNop, v, 1'b0, '0);
        act(mInPortOut | s);
    endtask

    task automatic setIr(instrWord w);
        busFromPort(mIrIn, w);
        // IR takes the word on the edge that opens this idle step
        act('0);
        checkInstr("ir", datapathTop_i.ir, w);
    endtask

    task automatic regsIr(logic [3:0] ra, logic [3:0] rb);
        instrWord w;
        w = '0;
        w.regForm.ra = ra;
        w.regForm.rb = rb;
        setIr(w);
    endtask

    task automatic writeReg(logic [3:0] k, logic [31:0] v);
        regsIr(k, 4'd0);
        busFromPort(mGra | mRin, v);
    endtask

    initial begin
        logic [31:0] vals [16];
        logic [31:0] a, b, pc, word;
        logic [4:0] ops [12];
        instrWord w;
        rngState = 32'd5;
        errors = 0;
        cycles = 0;
        arstN = 1'b0;
        {read, write, baOut, rin, rout, gra, grb, grc, marIn, mdrIn, yIn, zIn,
         pcIn, irIn, incPc, inPortIn, zOut, mdrOut, pcOut, inPortOut, cOut} = '0;
        opcode = '0;
        inPortData = '0;
        doCheck = 1'b0;
        expWord = '0;
        ops = '{opNop, opAdd, opSub, opShr, opShl, opShra,
                opRor, opRol, opAnd, opOr, opNeg, opNot};
        repeat (3) @(posedge clk);
        arstN <= 1'b1;

        // Register load and read back followed by R0 as zero base
        for (int k = 0; k < 16; k++) begin
            vals[k] = nextRand();
            writeReg(k[3:0], vals[k]);
        end
        for (int k = 0; k < 16; k++) begin
            regsIr(4'd0, k[3:0]);
            expectBus(mGrb | mRout, vals[k]);
        end
        regsIr(4'd0, 4'd0);
        expectBus(mGrb | mRout | mBaOut, '0);

        // Memory write then read through MDR
        for (int n = 0; n < 8; n++) begin
            word = nextRand();
            busFromPort(mMarIn, 32'(100 + n * 37));
            busFromPort(mMdrIn, word);
            act(mWrite);
            busFromPort(mMdrIn, '0);
            act(mRead | mMdrIn);
            expectBus(mMdrOut, word);
        end

        // ALU operations on two registers
        foreach (ops[i]) begin
            a = nextRand();
            b = nextRand();
            writeReg(4'd1, a);
            writeReg(4'd2, b);
            w = '0;
            w.regForm.rb = 4'd1;
            w.regForm.rc = 4'd2;
            setIr(w);
            act(mGrb | mRout | mYIn);
            step(mGrc | mRout | mZIn, ops[i], '0, 1'b0, '0);
            expectBus(mZOut, refAlu(ops[i], a, b));
        end

        // andi R2, R3, 0x25 fetched from memory
        writeReg(4'd3, 32'd5);
        w = '0;
        w.immForm.op = opAnd;
        w.immForm.ra = 4'd2;
        w.immForm.rb = 4'd3;
        w.immForm.constant = 19'h25;
        busFromPort(mMarIn, 32'd20);
        busFromPort(mMdrIn, w);
        act(mWrite);
        // Clear MAR so the fetch has to take its address from PC
        act(mMarIn);
        busFromPort(mPcIn, 32'd20);
        act(mPcOut | mMarIn);
        act(mRead | mMdrIn);
        act(mMdrOut | mIrIn);
        act(mGrb | mRout | mYIn);
        checkInstr("ir", datapathTop_i.ir, w);
        step(mCOut | mZIn, opAnd, '0, 1'b0, '0);
        act(mZOut | mGra | mRin);
        regsIr(4'd0, 4'd2);
        expectBus(mGrb | mRout, refAlu(opAnd, 32'd5, 32'h25));

        // PC increment through Z
        for (int n = 0; n < 6; n++) begin
            pc = nextRand();
            busFromPort(mPcIn, pc);
            act(mPcOut | mIncPc | mZIn);
            act(mZOut | mPcIn);
            expectBus(mPcOut, pc + 32'd1);
        end

        // Negative immediates widen with their sign
        for (int n = 0; n < 6; n++) begin
            w = nextRand();
            w.immForm.constant[18] = 1'b1;
            setIr(w);
            expectBus(mCOut, {13'h1fff, w.immForm.constant});
        end

        act('0);
        @(negedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end
endmodule

/* miniSrc.f */
logic/srcPkg.sv
logic/busIf.sv
logic/alu.sv
logic/memUnit.sv
logic/regFile.sv
logic/selectEncode.sv
logic/systemBus.sv
logic/datapathTop.sv
verification/datapath_assert.sv
verification/datapathTb.sv

/* run.sh */
#!/bin/sh
# Build and run the datapath testbench, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module datapathTb -f miniSrc.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^All tests passed!$" sim.log && echo "RUN PASSED" || { echo "RUN FAILED"; exit 1; }
